//--- verilog.f
common/imuldiv_pkg.sv
div/div_iterative_ctrl.sv
div/div_iterative_dpath.sv
div/div_iterative.sv
mul/mul_iterative.sv
source/imuldiv_unit.sv
dv/imuldiv_checker.sv
dv/imuldiv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the imuldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module imuldiv_tb \
  -f verilog.f -o imuldiv_sim

# the simulator exit status is folded into the log search below
./obj_dir/imuldiv_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- dv/imuldiv_tb.sv
// --------------------
// imuldiv testbench
// directed and random requests, reference model and result checks
// --------------------

`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_pkg::*;

  logic                clk;
  logic                reset;
  logic                req_val;
  logic                req_rdy;
  logic [fn_w-1:0]     req_fn;
  logic [data_w-1:0]   req_a;
  logic [data_w-1:0]   req_b;
  logic                resp_val;
  logic                resp_rdy;
  logic [result_w-1:0] resp_result;

  // expected results and test names, in request order
  logic [result_w-1:0] exp_q[$];
  string               name_q[$];
  int                  sent = 0;
  int                  recv = 0;
  int                  cycle = 0;
  // random back-pressure on the response side
  logic                stall_on = 1'b0;

  imuldiv_unit DUT (.*);

  bind imuldiv_unit imuldiv_checker chk (
    .clk(clk), .reset(reset), .req_val(req_val), .req_rdy(req_rdy),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp_result(resp_result)
  );

  always #2 clk = ~clk;

  // -------------------- reference model
  function automatic logic [result_w-1:0] model_result(input logic [fn_w-1:0] fn,
                                                       input logic [data_w-1:0] a,
                                                       input logic [data_w-1:0] b);
    longint            sa;
    longint            sb;
    logic [data_w-1:0] am;
    logic [data_w-1:0] bm;
    logic [data_w-1:0] q;
    logic [data_w-1:0] r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == fn_mul) begin
      return sa * sb;
    end else if (fn == fn_mulu) begin
      return 64'(a) * 64'(b);
    end
    // divide works on magnitudes, signs put back at the end
    am = (fn == fn_div && a[data_w-1]) ? ~a + 1'b1 : a;
    bm = (fn == fn_div && b[data_w-1]) ? ~b + 1'b1 : b;
    if (bm == '0) begin
      q = '1;
      r = am;
    end else begin
      q = am / bm;
      r = am % bm;
    end
    if (fn == fn_div && (a[data_w-1] ^ b[data_w-1])) q = ~q + 1'b1;
    if (fn == fn_div && a[data_w-1]) r = ~r + 1'b1;
    return {r, q};
  endfunction

  function automatic string fn_label(input logic [fn_w-1:0] fn);
    case (fn)
      fn_mul:  return "mul";
      fn_mulu: return "mulu";
      fn_div:  return "div";
      default: return "divu";
    endcase
  endfunction

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_req(input logic [fn_w-1:0] fn, input logic [data_w-1:0] a,
                          input logic [data_w-1:0] b, input string name);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    exp_q.push_back(model_result(fn, a, b));
    name_q.push_back(name);
    sent++;
    #1;
    req_val = 1'b0;
  endtask

  // -------------------- response side
  always @(posedge clk) begin : resp_side
    logic [result_w-1:0] exp;
    string               name;
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        $display("test failed");
        $fatal(1, "unexpected response");
      end else begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        recv++;
        assert (resp_result == exp) else begin
          $display("FAIL %s expected %h actual %h", name, exp, resp_result);
          $display("test failed");
          $fatal(1, "result mismatch");
        end
      end
    end
    #1;
    resp_rdy = stall_on ? (($urandom % 4) != 0) : 1'b1;
  end

  // -------------------- watchdog
  // 236 operations at no more than about 50 cycles each, plus reset
  always @(negedge clk) begin
    cycle++;
    if (cycle >= 12000) begin
      $display("timeout: run did not finish within 12000 cycles");
      $display("test failed");
      $fatal(1, "timeout");
    end else if (DUT.chk.err_cnt != 0) begin
      $display("a protocol assertion on the top level ports fired");
      $display("test failed");
      $fatal(1, "checker failure");
    end
  end

  // -------------------- stimulus
  initial begin
    logic [data_w-1:0] dir_a [9];
    logic [data_w-1:0] dir_b [9];
    logic [fn_w-1:0]   fn;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    void'($urandom(32'hf1b4848f));
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = '0;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    // sign mixes, zero, one, all ones, most negative, divide by zero
    dir_a = '{32'd7, 32'hfffffff9, 32'd7, 32'hfffffff9, 32'd0,
              32'h80000000, 32'd1, 32'd1234567, 32'hfffffb2e};
    dir_b = '{32'd3, 32'd3, 32'hfffffffd, 32'hfffffffd, 32'hffffffff,
              32'hffffffff, 32'h80000000, 32'd0, 32'd0};
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 9; i++) begin
      for (int f = 0; f < 4; f++) begin
        fn = fn_w'(f);
        send_req(fn, dir_a[i], dir_b[i], {fn_label(fn), " directed"});
      end
    end
    stall_on = 1'b1;
    for (int i = 0; i < 200; i++) begin
      fn = fn_w'($urandom % 4);
      a  = $urandom;
      b  = $urandom;
      // small divisors, zero among them, now and then
      if (($urandom % 8) == 0) b = $urandom % 4;
      send_req(fn, a, b, {fn_label(fn), " random"});
    end
    // drain, then watch for a stray response
    while (recv != sent) @(posedge clk);
    repeat (4) @(posedge clk);
    // let assertion actions of the last edge settle
    #1;
    if (recv == sent && exp_q.size() == 0 && DUT.chk.err_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("sent %0d operations, received %0d responses, %0d port assertion failures",
               sent, recv, DUT.chk.err_cnt);
      $display("test failed");
      $fatal(1, "end of run check failed");
    end
  end

endmodule

//--- dv/imuldiv_checker.sv
// --------------------
// imuldiv port checker
// handshake, latency and reset assertions on the top level
// --------------------

`timescale 1ns/1ps

module imuldiv_checker (
  input logic                               clk,
  input logic                               reset,
  input logic                               req_val,
  input logic                               req_rdy,
  input logic                               resp_val,
  input logic                               resp_rdy,
  input logic [imuldiv_pkg::result_w-1:0]   resp_result
);

  import imuldiv_pkg::*;

  logic accept;
  logic deliver;
  // one operation between acceptance and response transfer
  logic in_flight;
  // failures seen so far, polled by the testbench
  int   err_cnt = 0;

  assign accept  = req_val && req_rdy;
  assign deliver = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (accept) begin
      in_flight <= 1'b1;
    end else if (deliver) begin
      in_flight <= 1'b0;
    end
  end

  // -------------------- reset
  // first cycle out of reset is idle and ready
  reset_idle: assert property (@(posedge clk) $fell(reset) |-> !resp_val && req_rdy)
    else begin
      $error("unit not idle after reset");
      err_cnt++;
    end

  // -------------------- latency
  // 32 compute steps, response on the next edge
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(accept, iter_n + 1))
    else begin
      $error("resp_val did not rise 33 cycles after acceptance");
      err_cnt++;
    end

  busy_no_rdy: assert property (@(posedge clk) disable iff (reset) in_flight |-> !req_rdy)
    else begin
      $error("req_rdy high while an operation is in flight");
      err_cnt++;
    end

  // no response without a request behind it
  resp_owned: assert property (@(posedge clk) disable iff (reset) resp_val |-> in_flight)
    else begin
      $error("resp_val high with nothing in flight");
      err_cnt++;
    end

  // -------------------- back-pressure
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      $error("response dropped or changed under back-pressure");
      err_cnt++;
    end

endmodule

//--- source/imuldiv_unit.sv
// --------------------
// integer mul/div unit
// steers requests to the multiplier or divider and merges responses
// --------------------

`timescale 1ns/1ps

module imuldiv_unit (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req_val,
  output logic                               req_rdy,
  input  logic [imuldiv_pkg::fn_w-1:0]       req_fn,
  input  logic [imuldiv_pkg::data_w-1:0]     req_a,
  input  logic [imuldiv_pkg::data_w-1:0]     req_b,
  output logic                               resp_val,
  input  logic                               resp_rdy,
  output logic [imuldiv_pkg::result_w-1:0]   resp_result
);

  import imuldiv_pkg::*;

  logic                busy;
  // set when the divider owns the operation in flight
  logic                owner;
  logic                sel_div;
  logic                mul_req_val;
  logic                mul_req_rdy;
  logic                mul_resp_val;
  logic                mul_resp_rdy;
  logic [result_w-1:0] mul_resp_result;
  logic                div_req_val;
  logic                div_req_rdy;
  logic                div_resp_val;
  logic                div_resp_rdy;
  logic [result_w-1:0] div_resp_result;

  // -------------------- request steering
  // msb of the function code picks the divider
  assign sel_div     = req_fn[fn_w-1];
  // both units sit idle whenever nothing is in flight
  assign req_rdy     = !busy && mul_req_rdy && div_req_rdy;
  assign mul_req_val = req_val && req_rdy && !sel_div;
  assign div_req_val = req_val && req_rdy && sel_div;

  // -------------------- response merge
  assign resp_val     = owner ? div_resp_val : mul_resp_val;
  assign resp_result  = owner ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy && !owner;
  assign div_resp_rdy = resp_rdy && owner;

  // one operation at a time
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy  <= 1'b1;
      owner <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end
  end

  mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

endmodule

//--- mul/mul_iterative.sv
// --------------------
// iterative multiplier
// 32 shift-add steps on magnitudes, sign applied at the output
// --------------------

`timescale 1ns/1ps

module mul_iterative (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req_val,
  output logic                               req_rdy,
  input  logic [imuldiv_pkg::fn_w-1:0]       req_fn,
  input  logic [imuldiv_pkg::data_w-1:0]     req_a,
  input  logic [imuldiv_pkg::data_w-1:0]     req_b,
  output logic                               resp_val,
  input  logic                               resp_rdy,
  output logic [imuldiv_pkg::result_w-1:0]   resp_result
);

  import imuldiv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_t;

  state_t              state;
  logic [cnt_w-1:0]    cnt;
  // multiplicand moves left, multiplier moves right
  logic [result_w-1:0] mcand;
  logic [data_w-1:0]   mplier;
  logic [result_w-1:0] acc;
  logic                neg;
  logic                is_signed;
  logic [data_w-1:0]   a_mag;
  logic [data_w-1:0]   b_mag;
  logic                req_go;
  logic                resp_go;
  logic                step;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  assign step     = (state == st_calc);

  // -------------------- operand magnitudes
  assign is_signed = (req_fn == fn_mul);
  assign a_mag     = (is_signed && req_a[data_w-1]) ? -req_a : req_a;
  assign b_mag     = (is_signed && req_b[data_w-1]) ? -req_b : req_b;

  // -------------------- FSM and counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            cnt   <= cnt_w'(iter_n - 1);
          end
        end
        st_calc: begin
          cnt <= cnt - 1'b1;
          // step with cnt at zero is the last one
          if (cnt == '0) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // -------------------- shift-add datapath
  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand  <= result_w'(a_mag);
      mplier <= b_mag;
      acc    <= '0;
      // product sign only for the signed form
      neg    <= is_signed && (req_a[data_w-1] ^ req_b[data_w-1]);
    end else if (step) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // held stable through done
  assign resp_result = neg ? -acc : acc;

endmodule

//--- div/div_iterative.sv
// --------------------
// iterative divider
// restoring divide split into control and datapath
// --------------------

`timescale 1ns/1ps

module div_iterative (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req_val,
  output logic                               req_rdy,
  input  logic [imuldiv_pkg::fn_w-1:0]       req_fn,
  input  logic [imuldiv_pkg::data_w-1:0]     req_a,
  input  logic [imuldiv_pkg::data_w-1:0]     req_b,
  output logic                               resp_val,
  input  logic                               resp_rdy,
  output logic [imuldiv_pkg::result_w-1:0]   resp_result
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_sel;
  logic sub_sel;
  logic cnt_sel;
  logic sign_en;

  // datapath status back to control
  logic sub_neg;
  logic cnt_zero;

  // port names line up on both sides
  div_iterative_ctrl ctrl (.*);

  div_iterative_dpath dpath (.*);

endmodule

//--- div/div_iterative_dpath.sv
// --------------------
// divider datapath
// remainder/quotient register, shift-subtract step and sign fixup
// --------------------

`timescale 1ns/1ps

module div_iterative_dpath (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [imuldiv_pkg::fn_w-1:0]       req_fn,
  input  logic [imuldiv_pkg::data_w-1:0]     req_a,
  input  logic [imuldiv_pkg::data_w-1:0]     req_b,
  input  logic                               a_en,
  input  logic                               b_en,
  input  logic                               a_sel,
  input  logic                               sub_sel,
  input  logic                               cnt_sel,
  input  logic                               sign_en,
  output logic                               sub_neg,
  output logic                               cnt_zero,
  output logic [imuldiv_pkg::result_w-1:0]   resp_result
);

  import imuldiv_pkg::*;

  // remainder in [64:32], quotient in [31:0]
  logic [result_w:0]   a_reg;
  // divisor sits at [63:32]
  logic [result_w:0]   b_reg;
  logic [cnt_w-1:0]    cnt;
  logic                signed_q;
  logic                quo_sign;
  logic                rem_sign;
  logic                is_signed;
  logic [data_w-1:0]   a_mag;
  logic [data_w-1:0]   b_mag;
  logic [result_w:0]   a_shift;
  logic [result_w:0]   diff;
  logic [result_w:0]   a_step;
  logic [data_w-1:0]   quo;
  logic [data_w-1:0]   rem;

  // -------------------- operand magnitudes
  assign is_signed = (req_fn == fn_div);
  assign a_mag     = (is_signed && req_a[data_w-1]) ? -req_a : req_a;
  assign b_mag     = (is_signed && req_b[data_w-1]) ? -req_b : req_b;

  // -------------------- shift-subtract step
  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;
  assign sub_neg = diff[result_w];
  // restore drops the difference and shifts in a zero quotient bit
  assign a_step  = sub_sel ? a_shift : {diff[result_w:1], 1'b1};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_sel ? a_step : (result_w + 1)'(a_mag);
    end
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {data_w{1'b0}}};
    end
    if (sign_en) begin
      signed_q <= is_signed;
      quo_sign <= req_a[data_w-1] ^ req_b[data_w-1];
      rem_sign <= req_a[data_w-1];
    end
  end

  // -------------------- iteration counter
  // steps alongside the remainder register
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (a_en) begin
      cnt <= cnt_sel ? cnt - 1'b1 : cnt_w'(iter_n - 1);
    end
  end

  assign cnt_zero = (cnt == '0);

  // -------------------- sign correction
  // quotient takes the xor of signs, remainder the dividend sign
  assign quo = a_reg[data_w-1:0];
  assign rem = a_reg[result_w-1:data_w];

  assign resp_result = {(signed_q && rem_sign) ? -rem : rem,
                        (signed_q && quo_sign) ? -quo : quo};

endmodule

//--- div/div_iterative_ctrl.sv
// --------------------
// divider control
// idle/calc/done FSM driving the datapath enables and selects
// --------------------

`timescale 1ns/1ps

module div_iterative_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic sub_neg,
  input  logic cnt_zero,
  output logic a_en,
  output logic b_en,
  output logic a_sel,
  output logic sub_sel,
  output logic cnt_sel,
  output logic sign_en
);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_t;

  state_t state;
  state_t state_next;
  logic   req_go;
  logic   resp_go;

  // handshakes complete on these edges
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // -------------------- state register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // -------------------- next state and outputs
  always_comb begin
    state_next = state;
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    b_en       = 1'b0;
    a_sel      = 1'b0;
    sub_sel    = 1'b0;
    cnt_sel    = 1'b0;
    sign_en    = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load operands, signs and counter on the accepting edge
        a_en    = req_go;
        b_en    = req_go;
        sign_en = req_go;
        if (req_go) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // one shift-subtract step per cycle
        a_en    = 1'b1;
        a_sel   = 1'b1;
        cnt_sel = 1'b1;
        // negative trial result means restore
        sub_sel = sub_neg;
        // last step runs while the counter reads zero
        if (cnt_zero) begin
          state_next = st_done;
        end
      end
      st_done: begin
        resp_val = 1'b1;
        if (resp_go) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

//--- common/imuldiv_pkg.sv
// --------------------
// imuldiv shared definitions
// widths, function codes and iteration count of the mul/div unit
// --------------------

package imuldiv_pkg;

  // -------------------- widths

  // operand width
  localparam int data_w = 32;

  // full product, or remainder over quotient
  localparam int result_w = 2 * data_w;

  localparam int fn_w = 2;

  // -------------------- function codes

  // msb of the code picks the divider
  localparam logic [fn_w-1:0] fn_mul  = 2'd0;
  localparam logic [fn_w-1:0] fn_mulu = 2'd1;
  localparam logic [fn_w-1:0] fn_div  = 2'd2;
  localparam logic [fn_w-1:0] fn_divu = 2'd3;

  // -------------------- iteration

  // one result bit per step
  localparam int iter_n = 32;

  // counts iter_n-1 down to zero
  localparam int cnt_w = 5;

endpackage
